//--- design/axi_rd_pkg.sv
package axi_rd_pkg;

	// bus widths
	localparam int DATA_W     = 64;
	localparam int ADDR_W     = 32;
	localparam int ID_W       = 4;
	localparam int LEN_W      = 8;    // beats minus one
	localparam int SIZE_W     = 3;
	localparam int CPU_SIZE_W = 2;
	localparam int RESP_W     = 2;
	localparam int LANE_W     = 3;    // byte offset inside one beat
	localparam int NUM_LANES  = DATA_W / 8;

	// cpu size codes
	localparam logic [CPU_SIZE_W-1:0] CPU_SIZE_B1 = 2'd0;
	localparam logic [CPU_SIZE_W-1:0] CPU_SIZE_B2 = 2'd1;
	localparam logic [CPU_SIZE_W-1:0] CPU_SIZE_B4 = 2'd2;
	localparam logic [CPU_SIZE_W-1:0] CPU_SIZE_B8 = 2'd3;

	// axi arsize encodings
	localparam logic [SIZE_W-1:0] AXI_SIZE_B1 = 3'd0;
	localparam logic [SIZE_W-1:0] AXI_SIZE_B2 = 3'd1;
	localparam logic [SIZE_W-1:0] AXI_SIZE_B4 = 3'd2;
	localparam logic [SIZE_W-1:0] AXI_SIZE_B8 = 3'd3;

	// response codes
	localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

	// read fsm state codes
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_ADDR = 2'd1;
	localparam logic [ST_W-1:0] ST_DATA = 2'd2;

endpackage

//--- design/axi_rd_ctrl.sv
module axi_rd_ctrl (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          cpu_ar_valid_i,
	input  logic                          axi_ar_ready_i,
	input  logic                          axi_r_valid_i,
	input  logic                          axi_r_last_i,
	input  logic [axi_rd_pkg::LEN_W-1:0]  len_i,
	output logic                          cpu_ar_ready_o,
	output logic                          axi_ar_valid_o,
	output logic                          axi_r_ready_o,
	output logic                          req_take_o,
	output logic                          beat_take_o
);

	logic [axi_rd_pkg::ST_W-1:0]  state;
	logic [axi_rd_pkg::ST_W-1:0]  state_nxt;
	logic [axi_rd_pkg::LEN_W-1:0] beat_cnt;
	logic                         ar_done;
	logic                         final_beat;
	logic                         burst_done;

	// ready/valid straight from the state register
	assign cpu_ar_ready_o = (state == axi_rd_pkg::ST_IDLE);
	assign axi_ar_valid_o = (state == axi_rd_pkg::ST_ADDR);
	assign axi_r_ready_o  = (state == axi_rd_pkg::ST_DATA);

	// handshake decode
	assign req_take_o  = cpu_ar_valid_i & cpu_ar_ready_o;
	assign ar_done     = axi_ar_valid_o & axi_ar_ready_i;
	assign beat_take_o = axi_r_valid_i & axi_r_ready_o;
	assign burst_done  = beat_take_o & axi_r_last_i;

	assign final_beat = (beat_cnt == len_i);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= axi_rd_pkg::ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			axi_rd_pkg::ST_IDLE: begin
				if (req_take_o) begin
					state_nxt = axi_rd_pkg::ST_ADDR;
				end
			end
			axi_rd_pkg::ST_ADDR: begin
				if (ar_done) begin
					state_nxt = axi_rd_pkg::ST_DATA;
				end
			end
			axi_rd_pkg::ST_DATA: begin
				if (burst_done) begin   // slave marks the end
					state_nxt = axi_rd_pkg::ST_IDLE;
				end
			end
			default: begin
				state_nxt = axi_rd_pkg::ST_IDLE;
			end
		endcase
	end

	// beats seen so far in this burst
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_cnt <= '0;
		end else if (req_take_o) begin
			beat_cnt <= '0;
		end else if (beat_take_o) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// slave must flag last on beat len+1 and on no other
	a_last_on_final: assert property (
		@(posedge clk) disable iff (!reset_n)
		beat_take_o |-> (axi_r_last_i == final_beat)
	) else $error("axi_rd_ctrl: rlast at beat %0d, len %0d", beat_cnt, len_i);

	// arvalid must not be withdrawn before the slave takes it
	a_ar_hold: assert property (
		@(posedge clk) disable iff (!reset_n)
		axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o
	) else $error("axi_rd_ctrl: arvalid dropped without arready");

	a_ready_excl: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(cpu_ar_ready_o && axi_r_ready_o)
	) else $error("axi_rd_ctrl: cpu ready and rready both high");

endmodule

//--- design/axi_ar_gen.sv
module axi_ar_gen (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               req_take_i,
	input  logic [axi_rd_pkg::ID_W-1:0]        cpu_id_i,
	input  logic [axi_rd_pkg::ADDR_W-1:0]      cpu_addr_i,
	input  logic [axi_rd_pkg::LEN_W-1:0]       cpu_len_i,
	input  logic [axi_rd_pkg::CPU_SIZE_W-1:0]  cpu_size_i,
	output logic [axi_rd_pkg::ID_W-1:0]        axi_ar_id_o,
	output logic [axi_rd_pkg::ADDR_W-1:0]      axi_ar_addr_o,
	output logic [axi_rd_pkg::LEN_W-1:0]       axi_ar_len_o,
	output logic [axi_rd_pkg::SIZE_W-1:0]      axi_ar_size_o,
	output logic [axi_rd_pkg::LANE_W-1:0]      lane_off_o,
	output logic [axi_rd_pkg::CPU_SIZE_W-1:0]  size_code_o,
	output logic [axi_rd_pkg::LEN_W-1:0]       len_o
);

	logic [axi_rd_pkg::SIZE_W-1:0] ar_size;
	logic [axi_rd_pkg::ADDR_W-1:0] ar_addr;

	// cpu size code -> arsize
	always_comb begin
		case (cpu_size_i)
			axi_rd_pkg::CPU_SIZE_B1: ar_size = axi_rd_pkg::AXI_SIZE_B1;
			axi_rd_pkg::CPU_SIZE_B2: ar_size = axi_rd_pkg::AXI_SIZE_B2;
			axi_rd_pkg::CPU_SIZE_B4: ar_size = axi_rd_pkg::AXI_SIZE_B4;
			axi_rd_pkg::CPU_SIZE_B8: ar_size = axi_rd_pkg::AXI_SIZE_B8;
			default:                 ar_size = axi_rd_pkg::AXI_SIZE_B8;
		endcase
	end

	// bus address is always on a beat boundary
	assign ar_addr = {cpu_addr_i[axi_rd_pkg::ADDR_W-1:axi_rd_pkg::LANE_W],
		{axi_rd_pkg::LANE_W{1'b0}}};

	// ar channel payload, held for the whole burst
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			axi_ar_id_o   <= '0;
			axi_ar_addr_o <= '0;
			axi_ar_len_o  <= '0;
			axi_ar_size_o <= '0;
		end else if (req_take_i) begin
			axi_ar_id_o   <= cpu_id_i;
			axi_ar_addr_o <= ar_addr;
			axi_ar_len_o  <= cpu_len_i;
			axi_ar_size_o <= ar_size;
		end
	end

	// kept for lane masking of every beat
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			lane_off_o  <= '0;
			size_code_o <= '0;
		end else if (req_take_i) begin
			lane_off_o  <= cpu_addr_i[axi_rd_pkg::LANE_W-1:0];
			size_code_o <= cpu_size_i;
		end
	end

	assign len_o = axi_ar_len_o;   // beat count for the controller

endmodule

//--- design/axi_r_lane_mask.sv
module axi_r_lane_mask (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               beat_take_i,
	input  logic [axi_rd_pkg::DATA_W-1:0]      axi_r_data_i,
	input  logic [axi_rd_pkg::RESP_W-1:0]      axi_r_resp_i,
	input  logic                               axi_r_last_i,
	input  logic [axi_rd_pkg::LANE_W-1:0]      lane_off_i,
	input  logic [axi_rd_pkg::CPU_SIZE_W-1:0]  size_code_i,
	output logic                               cpu_r_valid_o,
	output logic [axi_rd_pkg::DATA_W-1:0]      cpu_r_data_o,
	output logic [axi_rd_pkg::RESP_W-1:0]      cpu_r_resp_o,
	output logic                               cpu_r_last_o
);

	logic [axi_rd_pkg::LANE_W:0]          n_bytes;    // 1..8
	logic [2*axi_rd_pkg::NUM_LANES-1:0]   span;
	logic [2*axi_rd_pkg::NUM_LANES-1:0]   span_shift;
	logic [axi_rd_pkg::NUM_LANES-1:0]     byte_en;
	logic [axi_rd_pkg::DATA_W-1:0]        data_mask;

	assign n_bytes = {{axi_rd_pkg::LANE_W{1'b0}}, 1'b1} << size_code_i;

	// run of n_bytes ones, moved up to the addressed lane
	assign span       = ({{(2*axi_rd_pkg::NUM_LANES-1){1'b0}}, 1'b1} << n_bytes) - 1'b1;
	assign span_shift = span << lane_off_i;
	assign byte_en    = span_shift[axi_rd_pkg::NUM_LANES-1:0];   // lanes past 7 fall off

	genvar g;
	generate
		for (g = 0; g < axi_rd_pkg::NUM_LANES; g++) begin : g_lane
			assign data_mask[8*g +: 8] = {8{byte_en[g]}};
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
		end else begin
			cpu_r_valid_o <= beat_take_i;   // one pulse per beat
		end
	end

	// beat payload, data stays in its own lanes
	always_ff @(posedge clk) begin
		if (beat_take_i) begin
			cpu_r_data_o <= axi_r_data_i & data_mask;
			cpu_r_resp_o <= axi_r_resp_i;
			cpu_r_last_o <= axi_r_last_i;
		end
	end

	// the pulse that ends a burst is never stretched
	a_valid_pulse: assert property (
		@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o && cpu_r_last_o |=> !cpu_r_valid_o
	) else $error("axi_r_lane_mask: cpu_r_valid_o held past the last beat");

endmodule

//--- design/axi_rd_bridge.sv
module axi_rd_bridge (
	input  logic                               clk,
	input  logic                               reset_n,

	// cpu request
	input  logic                               cpu_ar_valid_i,
	input  logic [axi_rd_pkg::ID_W-1:0]        cpu_id_i,
	input  logic [axi_rd_pkg::ADDR_W-1:0]      cpu_addr_i,
	input  logic [axi_rd_pkg::LEN_W-1:0]       cpu_len_i,
	input  logic [axi_rd_pkg::CPU_SIZE_W-1:0]  cpu_size_i,
	output logic                               cpu_ar_ready_o,

	// cpu result
	output logic                               cpu_r_valid_o,
	output logic [axi_rd_pkg::DATA_W-1:0]      cpu_r_data_o,
	output logic [axi_rd_pkg::RESP_W-1:0]      cpu_r_resp_o,
	output logic                               cpu_r_last_o,

	// axi ar
	output logic                               axi_ar_valid_o,
	input  logic                               axi_ar_ready_i,
	output logic [axi_rd_pkg::ID_W-1:0]        axi_ar_id_o,
	output logic [axi_rd_pkg::ADDR_W-1:0]      axi_ar_addr_o,
	output logic [axi_rd_pkg::LEN_W-1:0]       axi_ar_len_o,
	output logic [axi_rd_pkg::SIZE_W-1:0]      axi_ar_size_o,

	// axi r
	input  logic                               axi_r_valid_i,
	output logic                               axi_r_ready_o,
	input  logic [axi_rd_pkg::DATA_W-1:0]      axi_r_data_i,
	input  logic [axi_rd_pkg::RESP_W-1:0]      axi_r_resp_i,
	input  logic                               axi_r_last_i
);

	logic                              req_take;
	logic                              beat_take;
	logic [axi_rd_pkg::LANE_W-1:0]     lane_off;
	logic [axi_rd_pkg::CPU_SIZE_W-1:0] size_code;
	logic [axi_rd_pkg::LEN_W-1:0]      burst_len;

	axi_rd_ctrl u_ctrl (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_ar_valid_i (cpu_ar_valid_i),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_r_valid_i  (axi_r_valid_i),
		.axi_r_last_i   (axi_r_last_i),
		.len_i          (burst_len),
		.cpu_ar_ready_o (cpu_ar_ready_o),
		.axi_ar_valid_o (axi_ar_valid_o),
		.axi_r_ready_o  (axi_r_ready_o),
		.req_take_o     (req_take),
		.beat_take_o    (beat_take)
	);

	axi_ar_gen u_ar_gen (
		.clk           (clk),
		.reset_n       (reset_n),
		.req_take_i    (req_take),
		.cpu_id_i      (cpu_id_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_len_i     (cpu_len_i),
		.cpu_size_i    (cpu_size_i),
		.axi_ar_id_o   (axi_ar_id_o),
		.axi_ar_addr_o (axi_ar_addr_o),
		.axi_ar_len_o  (axi_ar_len_o),
		.axi_ar_size_o (axi_ar_size_o),
		.lane_off_o    (lane_off),
		.size_code_o   (size_code),
		.len_o         (burst_len)
	);

	axi_r_lane_mask u_lane_mask (
		.clk           (clk),
		.reset_n       (reset_n),
		.beat_take_i   (beat_take),
		.axi_r_data_i  (axi_r_data_i),
		.axi_r_resp_i  (axi_r_resp_i),
		.axi_r_last_i  (axi_r_last_i),
		.lane_off_i    (lane_off),
		.size_code_i   (size_code),
		.cpu_r_valid_o (cpu_r_valid_o),
		.cpu_r_data_o  (cpu_r_data_o),
		.cpu_r_resp_o  (cpu_r_resp_o),
		.cpu_r_last_o  (cpu_r_last_o)
	);

endmodule

//--- testbench/tb_clk_gen.sv
module tb_clk_gen (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#20 clk_o = ~clk_o;   // 40-unit period
		end
	end

endmodule

//--- testbench/tb_axi_slave_model.sv
module tb_axi_slave_model (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               ar_valid_i,
	output logic                               ar_ready_o,
	input  logic [axi_rd_pkg::ADDR_W-1:0]      ar_addr_i,
	input  logic [axi_rd_pkg::LEN_W-1:0]       ar_len_i,
	output logic                               r_valid_o,
	input  logic                               r_ready_i,
	output logic [axi_rd_pkg::DATA_W-1:0]      r_data_o,
	output logic [axi_rd_pkg::RESP_W-1:0]      r_resp_o,
	output logic                               r_last_o
);

	logic [15:0]                   lfsr;
	logic                          busy;
	logic                          in_reset;
	logic                          ar_fire;
	logic                          r_fire;
	logic                          pick;
	logic [axi_rd_pkg::ADDR_W-1:0] base;
	logic [axi_rd_pkg::LEN_W-1:0]  len;
	logic [axi_rd_pkg::LEN_W-1:0]  beat;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b    = lfsr[0];
	endtask

	// byte k of word A is the low byte of A+k
	function automatic logic [63:0] pattern_word(input logic [31:0] addr);
		logic [63:0] w;
		logic [31:0] a;
		for (int k = 0; k < 8; k++) begin
			a = addr + k;
			w[8*k +: 8] = a[7:0];
		end
		return w;
	endfunction

	task automatic drive_beat();
		logic [31:0] addr;
		addr     = base + {beat, 3'b000};
		r_data_o = pattern_word(addr);
		r_resp_o = (addr >= 32'h800) ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
		r_last_o = (beat == len);
	endtask

	initial begin
		lfsr       = 16'd65;
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_data_o   = '0;
		r_resp_o   = axi_rd_pkg::RESP_OKAY;
		r_last_o   = 1'b0;
		busy       = 1'b0;
		base       = '0;
		len        = '0;
		beat       = '0;
		forever begin
			// handshakes are settled mid-cycle
			@(negedge clk);
			in_reset = !reset_n;
			ar_fire  = ar_valid_i && ar_ready_o;
			r_fire   = r_valid_o && r_ready_i;
			if (ar_fire) begin
				base = ar_addr_i;
				len  = ar_len_i;
			end
			@(posedge clk);
			#5;
			if (in_reset) begin
				busy       = 1'b0;
				ar_ready_o = 1'b0;
				r_valid_o  = 1'b0;
				r_last_o   = 1'b0;
			end else begin
				if (ar_fire) begin
					busy       = 1'b1;
					beat       = '0;
					ar_ready_o = 1'b0;
				end else if (r_fire) begin
					r_valid_o = 1'b0;
					if (r_last_o) begin
						busy = 1'b0;
					end else begin
						beat = beat + 1'b1;
					end
				end
				if (!busy) begin
					random_bit(pick);
					ar_ready_o = pick;   // stall the address channel
				end else if (!r_valid_o) begin
					random_bit(pick);
					r_valid_o = pick;
					drive_beat();
				end
			end
		end
	end

endmodule

//--- testbench/tb_axi_rd_bridge.sv
module tb_axi_rd_bridge;

	logic                               clk;
	logic                               reset_n;
	logic                               cpu_ar_valid;
	logic [axi_rd_pkg::ID_W-1:0]        cpu_id;
	logic [axi_rd_pkg::ADDR_W-1:0]      cpu_addr;
	logic [axi_rd_pkg::LEN_W-1:0]       cpu_len;
	logic [axi_rd_pkg::CPU_SIZE_W-1:0]  cpu_size;
	logic                               cpu_ar_ready;
	logic                               cpu_r_valid;
	logic [axi_rd_pkg::DATA_W-1:0]      cpu_r_data;
	logic [axi_rd_pkg::RESP_W-1:0]      cpu_r_resp;
	logic                               cpu_r_last;
	logic                               axi_ar_valid;
	logic                               axi_ar_ready;
	logic [axi_rd_pkg::ID_W-1:0]        axi_ar_id;
	logic [axi_rd_pkg::ADDR_W-1:0]      axi_ar_addr;
	logic [axi_rd_pkg::LEN_W-1:0]       axi_ar_len;
	logic [axi_rd_pkg::SIZE_W-1:0]      axi_ar_size;
	logic                               axi_r_valid;
	logic                               axi_r_ready;
	logic [axi_rd_pkg::DATA_W-1:0]      axi_r_data;
	logic [axi_rd_pkg::RESP_W-1:0]      axi_r_resp;
	logic                               axi_r_last;

	// request list
	logic [axi_rd_pkg::ID_W-1:0]        req_id_q[$];
	logic [axi_rd_pkg::ADDR_W-1:0]      req_addr_q[$];
	logic [axi_rd_pkg::LEN_W-1:0]       req_len_q[$];
	logic [axi_rd_pkg::CPU_SIZE_W-1:0]  req_size_q[$];

	// request being tracked by the monitor
	logic                               req_open;
	logic [axi_rd_pkg::ID_W-1:0]        cur_id;
	logic [axi_rd_pkg::ADDR_W-1:0]      cur_addr;
	logic [axi_rd_pkg::LEN_W-1:0]       cur_len;
	logic [axi_rd_pkg::CPU_SIZE_W-1:0]  cur_size;
	int                                 ar_cnt;
	int                                 beat_cnt;
	logic                               ar_stalled;
	logic [axi_rd_pkg::ADDR_W-1:0]      held_addr;
	logic [axi_rd_pkg::ID_W-1:0]        held_id;
	logic [axi_rd_pkg::LEN_W-1:0]       held_len;
	logic [axi_rd_pkg::SIZE_W-1:0]      held_size;
	logic [axi_rd_pkg::ADDR_W-1:0]      exp_addr;
	logic [axi_rd_pkg::DATA_W-1:0]      exp_data;
	logic [axi_rd_pkg::RESP_W-1:0]      exp_resp;
	int                                 value_errs;
	int                                 proto_errs;

	tb_clk_gen clk_gen0 (
		.clk_o (clk)
	);

	axi_rd_bridge dut0 (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_ar_valid_i (cpu_ar_valid),
		.cpu_id_i       (cpu_id),
		.cpu_addr_i     (cpu_addr),
		.cpu_len_i      (cpu_len),
		.cpu_size_i     (cpu_size),
		.cpu_ar_ready_o (cpu_ar_ready),
		.cpu_r_valid_o  (cpu_r_valid),
		.cpu_r_data_o   (cpu_r_data),
		.cpu_r_resp_o   (cpu_r_resp),
		.cpu_r_last_o   (cpu_r_last),
		.axi_ar_valid_o (axi_ar_valid),
		.axi_ar_ready_i (axi_ar_ready),
		.axi_ar_id_o    (axi_ar_id),
		.axi_ar_addr_o  (axi_ar_addr),
		.axi_ar_len_o   (axi_ar_len),
		.axi_ar_size_o  (axi_ar_size),
		.axi_r_valid_i  (axi_r_valid),
		.axi_r_ready_o  (axi_r_ready),
		.axi_r_data_i   (axi_r_data),
		.axi_r_resp_i   (axi_r_resp),
		.axi_r_last_i   (axi_r_last)
	);

	tb_axi_slave_model slave0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.ar_valid_i (axi_ar_valid),
		.ar_ready_o (axi_ar_ready),
		.ar_addr_i  (axi_ar_addr),
		.ar_len_i   (axi_ar_len),
		.r_valid_o  (axi_r_valid),
		.r_ready_i  (axi_r_ready),
		.r_data_o   (axi_r_data),
		.r_resp_o   (axi_r_resp),
		.r_last_o   (axi_r_last)
	);

	task automatic value_mismatch(input string msg);
		value_errs++;
		$display("FAILED at time %0t: %s", $time, msg);
	endtask

	task automatic protocol_fault(input string msg);
		proto_errs++;
		$display("protocol error at time %0t: %s", $time, msg);
	endtask

	function automatic logic [63:0] expected_word(input logic [31:0] addr);
		logic [63:0] w;
		logic [31:0] a;
		for (int k = 0; k < 8; k++) begin
			a = addr + k;
			w[8*k +: 8] = a[7:0];
		end
		return w;
	endfunction

	// 2**size bytes from off upward, nothing past lane 7
	function automatic logic [63:0] lane_mask(input logic [2:0] off, input logic [1:0] size);
		logic [63:0] m;
		int          nbytes;
		m      = '0;
		nbytes = 1 << size;
		for (int k = 0; k < 8; k++) begin
			if (k >= off && k < off + nbytes) begin
				m[8*k +: 8] = 8'hff;
			end
		end
		return m;
	endfunction

	task automatic add_request(input logic [3:0] id, input logic [31:0] addr,
		input logic [7:0] len, input logic [1:0] size);
		req_id_q.push_back(id);
		req_addr_q.push_back(addr);
		req_len_q.push_back(len);
		req_size_q.push_back(size);
	endtask

	task automatic issue_read(input int idx);
		@(posedge clk);
		#5;
		cpu_ar_valid = 1'b1;
		cpu_id       = req_id_q[idx];
		cpu_addr     = req_addr_q[idx];
		cpu_len      = req_len_q[idx];
		cpu_size     = req_size_q[idx];
		do @(posedge clk); while (!req_open);
		#5;
		cpu_ar_valid = 1'b0;
		while (req_open) @(posedge clk);   // wait for the last beat
	endtask

	// all checks sample mid-cycle
	always @(negedge clk) begin
		if (reset_n) begin
			if (ar_stalled) begin
				assert (axi_ar_valid && axi_ar_addr == held_addr && axi_ar_id == held_id &&
					axi_ar_len == held_len && axi_ar_size == held_size)
				else value_mismatch("AR request changed while arready was low");
			end
			ar_stalled = axi_ar_valid && !axi_ar_ready;
			held_addr  = axi_ar_addr;
			held_id    = axi_ar_id;
			held_len   = axi_ar_len;
			held_size  = axi_ar_size;

			if (req_open) begin
				if (cpu_r_valid && beat_cnt == cur_len) begin
					assert (cpu_ar_ready)
					else value_mismatch("cpu_ar_ready_o low after the last beat");
				end else begin
					assert (!cpu_ar_ready)
					else value_mismatch("cpu_ar_ready_o high while a burst is open");
				end
			end

			if (axi_ar_valid && axi_ar_ready) begin
				assert (req_open && ar_cnt == 0)
				else protocol_fault("an AR transfer happened with no request waiting for one");
				assert (axi_ar_id == cur_id)
				else value_mismatch($sformatf("arid %0h, expected %0h", axi_ar_id, cur_id));
				assert (axi_ar_addr == (cur_addr & ~32'h7))
				else value_mismatch($sformatf("araddr %0h for request %0h", axi_ar_addr, cur_addr));
				assert (axi_ar_len == cur_len)
				else value_mismatch($sformatf("arlen %0d, expected %0d", axi_ar_len, cur_len));
				assert (axi_ar_size == {1'b0, cur_size})
				else value_mismatch($sformatf("arsize %0d, expected %0d", axi_ar_size, cur_size));
				ar_cnt++;
			end

			if (cpu_r_valid) begin
				assert (req_open && ar_cnt == 1)
				else protocol_fault("the bridge returned a beat with no burst on the bus");
				exp_addr = (cur_addr & ~32'h7) + beat_cnt * 8;
				exp_data = expected_word(exp_addr) & lane_mask(cur_addr[2:0], cur_size);
				exp_resp = (exp_addr >= 32'h800) ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
				assert (cpu_r_data == exp_data)
				else value_mismatch($sformatf("beat %0d data %h, expected %h",
					beat_cnt, cpu_r_data, exp_data));
				assert (cpu_r_resp == exp_resp)
				else value_mismatch($sformatf("beat %0d at %0h resp %0d, expected %0d",
					beat_cnt, exp_addr, cpu_r_resp, exp_resp));
				assert (cpu_r_last == (beat_cnt == cur_len))
				else value_mismatch($sformatf("beat %0d of len %0d has last %0b",
					beat_cnt, cur_len, cpu_r_last));
				if (beat_cnt == cur_len) begin
					req_open = 1'b0;
				end
				beat_cnt++;
			end

			if (cpu_ar_valid && cpu_ar_ready) begin
				cur_id   = cpu_id;
				cur_addr = cpu_addr;
				cur_len  = cpu_len;
				cur_size = cpu_size;
				ar_cnt   = 0;
				beat_cnt = 0;
				req_open = 1'b1;
			end
		end
	end

	initial begin
		reset_n      = 1'b0;
		cpu_ar_valid = 1'b0;
		cpu_id       = '0;
		cpu_addr     = '0;
		cpu_len      = '0;
		cpu_size     = '0;
		req_open     = 1'b0;
		ar_stalled   = 1'b0;
		ar_cnt       = 0;
		beat_cnt     = 0;
		value_errs   = 0;
		proto_errs   = 0;

		// every size, offset and length; 8 to 11 and 15 reach 0x800 and up
		add_request(4'h0, 32'h0000_0000, 8'd0, 2'd3);
		add_request(4'h1, 32'h0000_0101, 8'd1, 2'd0);
		add_request(4'h2, 32'h0000_0202, 8'd2, 2'd1);
		add_request(4'h3, 32'h0000_0303, 8'd3, 2'd2);
		add_request(4'h4, 32'h0000_0404, 8'd4, 2'd2);
		add_request(4'h5, 32'h0000_0405, 8'd5, 2'd2);
		add_request(4'h6, 32'h0000_0506, 8'd6, 2'd1);
		add_request(4'h7, 32'h0000_0607, 8'd7, 2'd0);
		add_request(4'h8, 32'h0000_07e7, 8'd7, 2'd1);
		add_request(4'h9, 32'h0000_07f8, 8'd3, 2'd3);
		add_request(4'ha, 32'h0000_0900, 8'd2, 2'd3);
		add_request(4'hb, 32'h0000_08fc, 8'd1, 2'd2);
		add_request(4'hc, 32'h0000_00a3, 8'd0, 2'd3);
		add_request(4'hd, 32'h0000_01f6, 8'd2, 2'd2);
		add_request(4'he, 32'h0000_0345, 8'd7, 2'd3);
		add_request(4'hf, 32'h0000_07e1, 8'd5, 2'd1);

		repeat (4) @(posedge clk);
		#5;
		reset_n = 1'b1;

		@(negedge clk);
		assert (!axi_ar_valid && !axi_r_ready && !cpu_r_valid && cpu_ar_ready)
		else value_mismatch("outputs after reset are not idle");

		for (int i = 0; i < req_addr_q.size(); i++) begin
			issue_read(i);
		end
		repeat (4) @(posedge clk);

		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// 400 cycles of 40 units for each request
	initial begin
		#1;
		#(req_addr_q.size() * 400 * 40);
		$display("timeout: the run did not finish within %0d cycles", req_addr_q.size() * 400);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- list.f
design/axi_rd_pkg.sv
design/axi_rd_ctrl.sv
design/axi_ar_gen.sv
design/axi_r_lane_mask.sv
design/axi_rd_bridge.sv
testbench/tb_clk_gen.sv
testbench/tb_axi_slave_model.sv
testbench/tb_axi_rd_bridge.sv

//--- Bender.yml
package:
  name: axi_rd_bridge

sources:
  - design/axi_rd_pkg.sv
  - design/axi_rd_ctrl.sv
  - design/axi_ar_gen.sv
  - design/axi_r_lane_mask.sv
  - design/axi_rd_bridge.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_axi_slave_model.sv
      - testbench/tb_axi_rd_bridge.sv
